/* compile.f */
logic/commit_pkg.sv
logic/writeback_router.sv
logic/gpr_file.sv
logic/seg_file.sv
logic/writeback_top.sv
dv/tb_clock_gen.sv
dv/tb_writeback.sv

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reset held low over five rising edges
   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* dv/tb_writeback.sv */
`timescale 1ns/1ps

module tb_writeback;

   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 400;
   localparam int RESET_CYCLES    = 5;
   localparam int CLK_PERIOD_NS   = 10;
   localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD_NS;

   logic clk;
   logic rst_n;

   commit_pkg::wb_packet_t wb_in;
   commit_pkg::dec_wb_t    dec_wb;
   commit_pkg::mem_write_t wmem;
   commit_pkg::sys_req_t   sys_req;
   commit_pkg::reg_idx_t   gpr_rd_idx_a;
   commit_pkg::reg_idx_t   gpr_rd_idx_b;
   commit_pkg::reg_idx_t   seg_rd_idx;
   logic [31:0]            gpr_rd_data_a;
   logic [31:0]            gpr_rd_data_b;
   logic [15:0]            seg_rd_data;

   // reference state for the register files
   logic [31:0] model_gpr [8];
   logic [15:0] model_seg [6];

   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int seed = 97;

   tb_clock_gen i_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   writeback_top i_writeback_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .wb_in         (wb_in),
      .dec_wb        (dec_wb),
      .wmem          (wmem),
      .sys_req       (sys_req),
      .gpr_rd_idx_a  (gpr_rd_idx_a),
      .gpr_rd_idx_b  (gpr_rd_idx_b),
      .seg_rd_idx    (seg_rd_idx),
      .gpr_rd_data_a (gpr_rd_data_a),
      .gpr_rd_data_b (gpr_rd_data_b),
      .seg_rd_data   (seg_rd_data)
   );

   // byte writes to 4..7 land in the high byte of register index minus 4
   function automatic commit_pkg::reg_idx_t model_target(
      input commit_pkg::reg_idx_t idx,
      input commit_pkg::op_size_e size
   );
      if (size == commit_pkg::SIZE_BYTE && idx >= 4) begin
         return idx - 3'd4;
      end
      return idx;
   endfunction

   function automatic logic [31:0] model_merge(
      input logic [31:0]          old,
      input commit_pkg::reg_idx_t idx,
      input commit_pkg::op_size_e size,
      input logic [31:0]          data
   );
      logic [31:0] v;
      v = old;
      if (size == commit_pkg::SIZE_BYTE) begin
         if (idx >= 4) begin
            v[15:8] = data[7:0];
         end else begin
            v[7:0] = data[7:0];
         end
      end else if (size == commit_pkg::SIZE_WORD) begin
         v[15:0] = data[15:0];
      end else begin
         v = data;
      end
      return v;
   endfunction

   // routing rules on the reference state where port a wins a collision
   task automatic model_apply(input commit_pkg::wb_packet_t p, input commit_pkg::dec_wb_t d);
      logic                 a_en;
      logic                 b_en;
      commit_pkg::reg_idx_t a_idx;
      commit_pkg::op_size_e a_size;
      logic [31:0]          a_data;
      commit_pkg::reg_idx_t a_tgt;
      commit_pkg::reg_idx_t b_tgt;
      logic [31:0]          a_val;
      logic [31:0]          b_val;
      b_en = p.valid && (p.alu_op == commit_pkg::ALU_XCHG) && p.op_b_is_reg;
      if (d.valid) begin
         a_en   = 1'b1;
         a_idx  = d.idx;
         a_size = commit_pkg::op_size_e'(d.size[1:0]);
         a_data = d.data;
      end else begin
         a_en   = p.valid && (p.dest_kind == commit_pkg::DEST_REG);
         a_idx  = p.dest_reg;
         a_size = p.opsize;
         a_data = p.result.dw.lower;
      end
      a_tgt = model_target(a_idx, a_size);
      b_tgt = model_target(p.op_b_reg, p.opsize);
      a_val = model_merge(model_gpr[a_tgt], a_idx, a_size, a_data);
      b_val = model_merge(model_gpr[b_tgt], p.op_b_reg, p.opsize, p.result.dw.upper);
      if (b_en) begin
         model_gpr[b_tgt] = b_val;
      end
      if (a_en) begin
         model_gpr[a_tgt] = a_val;
      end
      if (p.valid && p.dest_kind == commit_pkg::DEST_SEG && p.dest_reg < 6) begin
         model_seg[p.dest_reg] = p.result.dw.lower[15:0];
      end
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   function automatic commit_pkg::wb_packet_t exec_pkt(
      input commit_pkg::dest_kind_e kind,
      input commit_pkg::reg_idx_t   dest,
      input commit_pkg::op_size_e   size,
      input logic [63:0]            data
   );
      commit_pkg::wb_packet_t p;
      p            = '0;
      p.valid      = 1'b1;
      p.dest_kind  = kind;
      p.dest_reg   = dest;
      p.opsize     = size;
      p.result.raw = data;
      return p;
   endfunction

   task automatic send(input commit_pkg::wb_packet_t p, input commit_pkg::dec_wb_t d);
      @(posedge clk);
      wb_in  <= p;
      dec_wb <= d;
      model_apply(p, d);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         wb_in  <= '0;
         dec_wb <= '0;
      end
   endtask

   // walks all indices on both gpr ports and the segment port
   task automatic check_regs();
      logic [15:0] seg_exp;
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
         gpr_rd_idx_a <= commit_pkg::reg_idx_t'(i);
         gpr_rd_idx_b <= commit_pkg::reg_idx_t'(7 - i);
         seg_rd_idx   <= commit_pkg::reg_idx_t'(i);
         @(negedge clk);
         seg_exp = (i < 6) ? model_seg[i] : 16'h0000;
         check_val($sformatf("gpr_rd_data_a[%0d]", i), gpr_rd_data_a, model_gpr[i]);
         check_val($sformatf("gpr_rd_data_b[%0d]", 7 - i), gpr_rd_data_b, model_gpr[7 - i]);
         check_val($sformatf("seg_rd_data[%0d]", i), seg_rd_data, seg_exp);
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         $display("[%0t ns] %s: ok", $time, name);
      end else begin
         tests_failed++;
         $display("[%0t ns] %s: %0d errors", $time, name, errors - err_before);
      end
   endtask

   // write, then read the merged register two cycles later
   task automatic write_then_read(input commit_pkg::wb_packet_t p, input commit_pkg::reg_idx_t rd);
      send(p, '0);
      idle(1);
      gpr_rd_idx_a <= rd;
      idle(1);
      @(negedge clk);
      check_val($sformatf("gpr_rd_data_a[%0d]", rd), gpr_rd_data_a, model_gpr[rd]);
   endtask

   task automatic test_reset_and_sizes();
      int err_before;
      err_before = errors;
      @(negedge clk);
      check_val("wmem.valid", wmem.valid, 0);
      check_val("sys_req.valid", sys_req.valid, 0);
      check_regs();
      write_then_read(exec_pkt(commit_pkg::DEST_REG, 2, commit_pkg::SIZE_DWORD, 64'h11223344), 2);
      write_then_read(exec_pkt(commit_pkg::DEST_REG, 2, commit_pkg::SIZE_WORD, 64'hAABB), 2);
      write_then_read(exec_pkt(commit_pkg::DEST_REG, 2, commit_pkg::SIZE_BYTE, 64'hCC), 2);
      // index 6 is the high byte of register 2
      write_then_read(exec_pkt(commit_pkg::DEST_REG, 6, commit_pkg::SIZE_BYTE, 64'hDD), 2);
      report_test("reset and sizes", err_before);
   endtask

   task automatic test_mem_dest();
      int                     err_before;
      commit_pkg::wb_packet_t p;
      err_before     = errors;
      p              = exec_pkt(commit_pkg::DEST_MEM, 1, commit_pkg::SIZE_QWORD,
                                64'hDEAD_BEEF_0123_4567);
      p.dest_address = 32'h0000_4F00;
      send(p, '0);
      idle(1);
      @(negedge clk);
      check_val("wmem.valid", wmem.valid, 1);
      check_val("wmem.address", wmem.address, p.dest_address);
      check_val("wmem.data", wmem.data, p.result.raw);
      check_val("wmem.size", wmem.size, p.opsize);
      idle(1);
      @(negedge clk);
      check_val("wmem.valid", wmem.valid, 0);
      check_regs();
      report_test("memory destination", err_before);
   endtask

   task automatic test_exchange();
      int                     err_before;
      commit_pkg::wb_packet_t p;
      err_before    = errors;
      p             = exec_pkt(commit_pkg::DEST_REG, 1, commit_pkg::SIZE_DWORD,
                               64'hBBBB_0005_AAAA_0001);
      p.alu_op      = commit_pkg::ALU_XCHG;
      p.op_b_reg    = 5;
      p.op_b_is_reg = 1'b1;
      send(p, '0);
      idle(2);
      check_regs();
      // operand b in memory
      p                 = exec_pkt(commit_pkg::DEST_REG, 3, commit_pkg::SIZE_DWORD,
                                   64'hCAFE_F00D_1357_9BDF);
      p.alu_op          = commit_pkg::ALU_XCHG;
      p.op_b_is_address = 1'b1;
      p.op_b_address    = 32'h8000_1000;
      send(p, '0);
      idle(1);
      @(negedge clk);
      check_val("wmem.valid", wmem.valid, 1);
      check_val("wmem.address", wmem.address, 32'h8000_1000);
      check_val("wmem.data", wmem.data, 64'h0000_0000_CAFE_F00D);
      idle(1);
      check_regs();
      report_test("exchange", err_before);
   endtask

   task automatic test_decoder_priority();
      int                     err_before;
      commit_pkg::wb_packet_t p;
      commit_pkg::dec_wb_t    d;
      err_before = errors;
      p          = exec_pkt(commit_pkg::DEST_REG, 4, commit_pkg::SIZE_DWORD, 64'h4444_4444);
      d          = '{valid: 1'b1, idx: 3'd7, size: 3'd2, data: 32'h7777_0007};
      send(p, d);
      idle(2);
      check_regs();
      // port b still writes during a decoder write
      p             = exec_pkt(commit_pkg::DEST_REG, 0, commit_pkg::SIZE_DWORD,
                               64'h6666_0006_0000_0F0F);
      p.alu_op      = commit_pkg::ALU_XCHG;
      p.op_b_reg    = 6;
      p.op_b_is_reg = 1'b1;
      d             = '{valid: 1'b1, idx: 3'd2, size: 3'd1, data: 32'h0000_2222};
      send(p, d);
      idle(2);
      check_regs();
      report_test("decoder priority", err_before);
   endtask

   task automatic test_seg_and_sys();
      int                     err_before;
      commit_pkg::wb_packet_t p;
      err_before = errors;
      for (int i = 0; i < 8; i++) begin
         send(exec_pkt(commit_pkg::DEST_SEG, commit_pkg::reg_idx_t'(i), commit_pkg::SIZE_WORD,
                       64'h5A5A_0000 + 64'h1111 * (i + 1)), '0);
      end
      idle(2);
      check_regs();
      p                   = exec_pkt(commit_pkg::DEST_NONE, 0, commit_pkg::SIZE_QWORD,
                                     64'h0BAD_C0DE_2468_ACE0);
      p.to_sys_controller = 1'b1;
      p.pc                = 32'h0010_2030;
      send(p, '0);
      idle(1);
      @(negedge clk);
      check_val("sys_req.valid", sys_req.valid, 1);
      check_val("sys_req.data", sys_req.data, p.result.raw);
      check_val("sys_req.pc", sys_req.pc, p.pc);
      idle(1);
      @(negedge clk);
      check_val("sys_req.valid", sys_req.valid, 0);
      report_test("segments and system controller", err_before);
   endtask

   task automatic test_random_traffic();
      int                     err_before;
      int                     r;
      commit_pkg::wb_packet_t p;
      commit_pkg::dec_wb_t    d;
      err_before = errors;
      for (int n = 0; n < 200; n++) begin
         r                   = $random(seed);
         p.valid             = (r[2:0] != 3'd0);
         p.alu_op            = (r[4:3] == 2'd0) ? commit_pkg::ALU_XCHG : r[8:5];
         p.opsize            = commit_pkg::op_size_e'(r[10:9]);
         p.dest_kind         = commit_pkg::dest_kind_e'(r[12:11]);
         p.dest_reg          = r[15:13];
         p.op_b_reg          = r[18:16];
         p.op_b_is_reg       = r[19];
         p.op_b_is_address   = r[20];
         p.to_sys_controller = r[21];
         p.result.raw        = {$random(seed), $random(seed)};
         p.dest_address      = $random(seed);
         p.op_b_address      = $random(seed);
         p.pc                = $random(seed);
         // occasional decoder write on the same cycle
         d.valid             = (r[24:22] == 3'd0);
         d.idx               = r[27:25];
         d.size              = {1'b0, r[29:28]};
         d.data              = $random(seed);
         send(p, d);
      end
      idle(2);
      check_regs();
      report_test("random traffic", err_before);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      wb_in        = '0;
      dec_wb       = '0;
      gpr_rd_idx_a = '0;
      gpr_rd_idx_b = '0;
      seg_rd_idx   = '0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < 8; i++) begin
         model_gpr[i] = '0;
      end
      for (int i = 0; i < 6; i++) begin
         model_seg[i] = '0;
      end
      @(posedge rst_n);
      test_reset_and_sizes();
      test_mem_dest();
      test_exchange();
      test_decoder_priority();
      test_seg_and_sys();
      test_random_traffic();
      $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* logic/commit_pkg.sv */
package commit_pkg;

   // datapath widths
   localparam int DWORD_W = 32;
   localparam int QWORD_W = 64;
   localparam int SEG_W   = 16;
   localparam int ADDR_W  = 32;

   // architectural register counts
   localparam int NUM_GPR = 8;
   localparam int NUM_SEG = 6;

   typedef logic [2:0] reg_idx_t;
   typedef logic [3:0] alu_op_t;

   // exchange opcode from the ALU op table
   localparam alu_op_t ALU_XCHG = 4'd14;

   typedef enum logic [1:0] {
      SIZE_BYTE  = 2'd0,
      SIZE_WORD  = 2'd1,
      SIZE_DWORD = 2'd2,
      SIZE_QWORD = 2'd3
   } op_size_e;

   // where operand a lands after execute
   typedef enum logic [1:0] {
      DEST_NONE = 2'd0,
      DEST_REG  = 2'd1,
      DEST_MEM  = 2'd2,
      DEST_SEG  = 2'd3
   } dest_kind_e;

   // lower is the new op a and upper the new op b of an exchange
   typedef struct packed {
      logic [DWORD_W-1:0] upper;
      logic [DWORD_W-1:0] lower;
   } dword_pair_t;

   typedef union packed {
      logic [QWORD_W-1:0] raw;
      dword_pair_t        dw;
   } wb_result_u;

   typedef struct packed {
      logic              valid;
      alu_op_t           alu_op;
      op_size_e          opsize;
      dest_kind_e        dest_kind;
      reg_idx_t          dest_reg;
      logic [ADDR_W-1:0] dest_address;
      wb_result_u        result;
      reg_idx_t          op_b_reg;
      logic [ADDR_W-1:0] op_b_address;
      logic              op_b_is_reg;
      logic              op_b_is_address;
      logic              to_sys_controller;
      logic [ADDR_W-1:0] pc;
   } wb_packet_t;

   // low two bits of the 3-bit decoder size code follow op_size_e
   typedef struct packed {
      logic               valid;
      reg_idx_t           idx;
      logic [2:0]         size;
      logic [DWORD_W-1:0] data;
   } dec_wb_t;

   typedef struct packed {
      logic               en;
      reg_idx_t           idx;
      op_size_e           size;
      logic [DWORD_W-1:0] data;
   } reg_write_t;

   typedef struct packed {
      logic             en;
      reg_idx_t         idx;
      logic [SEG_W-1:0] data;
   } seg_write_t;

   typedef struct packed {
      logic               valid;
      logic [ADDR_W-1:0]  address;
      logic [QWORD_W-1:0] data;
      op_size_e           size;
   } mem_write_t;

   typedef struct packed {
      logic               valid;
      logic [QWORD_W-1:0] data;
      logic [ADDR_W-1:0]  pc;
   } sys_req_t;

endpackage

/* logic/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
   input  logic                              clk,
   input  logic                              rst_n,
   input  commit_pkg::reg_write_t            wr_a,
   input  commit_pkg::reg_write_t            wr_b,
   input  commit_pkg::reg_idx_t              rd_idx_a,
   input  commit_pkg::reg_idx_t              rd_idx_b,
   output logic [commit_pkg::DWORD_W-1:0]    rd_data_a,
   output logic [commit_pkg::DWORD_W-1:0]    rd_data_b
);

   logic [commit_pkg::DWORD_W-1:0] regs [commit_pkg::NUM_GPR];

   // byte writes to 4..7 hit AH, CH, DH, BH in registers 0..3
   function automatic commit_pkg::reg_idx_t target_idx(
      input commit_pkg::reg_write_t wr
   );
      commit_pkg::reg_idx_t t;
      t = wr.idx;
      if (wr.size == commit_pkg::SIZE_BYTE && wr.idx[2]) begin
         t = {1'b0, wr.idx[1:0]};
      end
      return t;
   endfunction

   // merge the write into the old value according to its size
   function automatic logic [commit_pkg::DWORD_W-1:0] merge(
      input logic [commit_pkg::DWORD_W-1:0] old,
      input commit_pkg::reg_write_t         wr
   );
      logic [commit_pkg::DWORD_W-1:0] v;
      v = old;
      case (wr.size)
         commit_pkg::SIZE_BYTE: begin
            if (wr.idx[2]) begin
               v[15:8] = wr.data[7:0];
            end else begin
               v[7:0] = wr.data[7:0];
            end
         end
         commit_pkg::SIZE_WORD: begin
            v[15:0] = wr.data[15:0];
         end
         default: begin
            // dword and qword both fill the full register
            v = wr.data;
         end
      endcase
      return v;
   endfunction

   commit_pkg::reg_idx_t tgt_a;
   commit_pkg::reg_idx_t tgt_b;

   assign tgt_a = target_idx(wr_a);
   assign tgt_b = target_idx(wr_b);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < commit_pkg::NUM_GPR; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < commit_pkg::NUM_GPR; i++) begin
            // port a is applied last so it wins a collision
            if (wr_b.en && tgt_b == commit_pkg::reg_idx_t'(i)) begin
               regs[i] <= merge(regs[i], wr_b);
            end
            if (wr_a.en && tgt_a == commit_pkg::reg_idx_t'(i)) begin
               regs[i] <= merge(regs[i], wr_a);
            end
         end
      end
   end

   // read ports are combinational
   assign rd_data_a = regs[rd_idx_a];
   assign rd_data_b = regs[rd_idx_b];

endmodule

/* logic/seg_file.sv */
`timescale 1ns/1ps

module seg_file (
   input  logic                           clk,
   input  logic                           rst_n,
   input  commit_pkg::seg_write_t         wr,
   input  commit_pkg::reg_idx_t           rd_idx,
   output logic [commit_pkg::SEG_W-1:0]   rd_data
);

   // ES, CS, SS, DS, FS, GS
   logic [commit_pkg::SEG_W-1:0] segs [commit_pkg::NUM_SEG];

   logic wr_in_range;
   logic rd_in_range;

   // indices 6 and 7 have no register behind them
   assign wr_in_range = (wr.idx < commit_pkg::NUM_SEG);
   assign rd_in_range = (rd_idx < commit_pkg::NUM_SEG);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < commit_pkg::NUM_SEG; i++) begin
            segs[i] <= '0;
         end
      end else if (wr.en && wr_in_range) begin
         segs[wr.idx] <= wr.data;
      end
   end

   assign rd_data = rd_in_range ? segs[rd_idx] : '0;

endmodule

/* logic/writeback_router.sv */
`timescale 1ns/1ps

module writeback_router (
   input  logic                   clk,
   input  logic                   rst_n,
   input  commit_pkg::wb_packet_t wb_in,
   input  commit_pkg::dec_wb_t    dec_wb,
   output commit_pkg::reg_write_t gpr_wr_a,
   output commit_pkg::reg_write_t gpr_wr_b,
   output commit_pkg::seg_write_t seg_wr,
   output commit_pkg::mem_write_t wmem,
   output commit_pkg::sys_req_t   sys_req
);

   logic is_xchg;
   logic xchg_to_mem;
   logic exec_reg;

   commit_pkg::reg_write_t a_next;
   commit_pkg::reg_write_t b_next;
   commit_pkg::seg_write_t seg_next;
   commit_pkg::mem_write_t mem_next;
   commit_pkg::sys_req_t   sys_next;

   assign is_xchg     = (wb_in.alu_op == commit_pkg::ALU_XCHG);
   // exchange with a memory operand b goes out on the write bus
   assign xchg_to_mem = is_xchg && wb_in.op_b_is_address;
   assign exec_reg    = wb_in.valid && (wb_in.dest_kind == commit_pkg::DEST_REG);

   // memory write request
   always_comb begin
      mem_next.valid = wb_in.valid &&
                       ((wb_in.dest_kind == commit_pkg::DEST_MEM) || xchg_to_mem);
      mem_next.size  = wb_in.opsize;
      if (xchg_to_mem) begin
         mem_next.address = wb_in.op_b_address;
         mem_next.data    = {{commit_pkg::DWORD_W{1'b0}}, wb_in.result.dw.upper};
      end else begin
         mem_next.address = wb_in.dest_address;
         mem_next.data    = wb_in.result.raw;
      end
   end

   // decoder write takes port a over the executed result
   always_comb begin
      if (dec_wb.valid) begin
         a_next.en   = 1'b1;
         a_next.idx  = dec_wb.idx;
         a_next.size = commit_pkg::op_size_e'(dec_wb.size[1:0]);
         a_next.data = dec_wb.data;
      end else begin
         a_next.en   = exec_reg;
         a_next.idx  = wb_in.dest_reg;
         a_next.size = wb_in.opsize;
         a_next.data = wb_in.result.dw.lower;
      end
   end

   // port b only carries the second half of a register exchange
   always_comb begin
      b_next.en   = wb_in.valid && is_xchg && wb_in.op_b_is_reg;
      b_next.idx  = wb_in.op_b_reg;
      b_next.size = wb_in.opsize;
      b_next.data = wb_in.result.dw.upper;
   end

   always_comb begin
      seg_next.en   = wb_in.valid && (wb_in.dest_kind == commit_pkg::DEST_SEG);
      seg_next.idx  = wb_in.dest_reg;
      seg_next.data = wb_in.result.dw.lower[commit_pkg::SEG_W-1:0];
   end

   // system controller sees the full result and the next pc
   always_comb begin
      sys_next.valid = wb_in.valid && wb_in.to_sys_controller;
      sys_next.data  = wb_in.result.raw;
      sys_next.pc    = wb_in.pc;
   end

   // one register stage on every output
   always_ff @(posedge clk) begin
      gpr_wr_a <= a_next;
      gpr_wr_b <= b_next;
      seg_wr   <= seg_next;
      wmem     <= mem_next;
      sys_req  <= sys_next;
      if (!rst_n) begin
         gpr_wr_a.en   <= 1'b0;
         gpr_wr_b.en   <= 1'b0;
         seg_wr.en     <= 1'b0;
         wmem.valid    <= 1'b0;
         sys_req.valid <= 1'b0;
      end
   end

endmodule

/* logic/writeback_top.sv */
`timescale 1ns/1ps

module writeback_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  commit_pkg::wb_packet_t            wb_in,
   input  commit_pkg::dec_wb_t               dec_wb,
   output commit_pkg::mem_write_t            wmem,
   output commit_pkg::sys_req_t              sys_req,
   input  commit_pkg::reg_idx_t              gpr_rd_idx_a,
   input  commit_pkg::reg_idx_t              gpr_rd_idx_b,
   input  commit_pkg::reg_idx_t              seg_rd_idx,
   output logic [commit_pkg::DWORD_W-1:0]    gpr_rd_data_a,
   output logic [commit_pkg::DWORD_W-1:0]    gpr_rd_data_b,
   output logic [commit_pkg::SEG_W-1:0]      seg_rd_data
);

   // registered write ports from the router
   commit_pkg::reg_write_t gpr_wr_a;
   commit_pkg::reg_write_t gpr_wr_b;
   commit_pkg::seg_write_t seg_wr;

   writeback_router i_router (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_in    (wb_in),
      .dec_wb   (dec_wb),
      .gpr_wr_a (gpr_wr_a),
      .gpr_wr_b (gpr_wr_b),
      .seg_wr   (seg_wr),
      .wmem     (wmem),
      .sys_req  (sys_req)
   );

   // port a of the general registers is the primary commit port
   gpr_file i_gpr_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_a      (gpr_wr_a),
      .wr_b      (gpr_wr_b),
      .rd_idx_a  (gpr_rd_idx_a),
      .rd_idx_b  (gpr_rd_idx_b),
      .rd_data_a (gpr_rd_data_a),
      .rd_data_b (gpr_rd_data_b)
   );

   seg_file i_seg_file (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr      (seg_wr),
      .rd_idx  (seg_rd_idx),
      .rd_data (seg_rd_data)
   );

endmodule
